// ==== hbridge_pkg.sv ====
`default_nettype none

package hbridge_pkg;

   // =========================================================================
   // datapath widths
   // =========================================================================

   // signed tank sample from the ADC, also its negation
   typedef logic signed [13:0] adc_sample_t;

   // offset-binary word for the DAC copies
   typedef logic [13:0] dac_word_t;

   // mosfet gates
   // bit 0 M1, bit 1 M2, bit 2 M3, bit 3 M4
   // leg 1 is M1/M3, leg 2 is M2/M4
   typedef logic [3:0] gate_t;

   // phi setpoint in degrees
   typedef logic [7:0] angle_t;

   // dead time and start-up counters, in clock cycles
   typedef logic [7:0] dt_count_t;
   typedef logic [7:0] startup_cnt_t;

   // bridge start-up sequence
   typedef enum logic [1:0] {
      st_off,
      st_bootstrap,
      st_force,
      st_run
   } bridge_state_t;

   // =========================================================================
   // fixed constants
   // =========================================================================

   // mid-scale for the 14-bit DAC
   localparam dac_word_t DAC_OFFSET = 14'd8191;
   // low side on, charges the bootstrap caps
   localparam gate_t GATES_BOOTSTRAP = 4'b1100;
   // M1 and M4 on, forced initial state
   localparam gate_t GATES_FORCE = 4'b1001;

endpackage

`default_nettype wire

// ==== adc_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module adc_capture (
   input  wire                           i_reset,
   input  wire                           ADA_DCO,
   input  wire hbridge_pkg::adc_sample_t i_ada_data,
   input  wire hbridge_pkg::adc_sample_t i_adb_data,
   output hbridge_pkg::adc_sample_t      o_vc,
   output hbridge_pkg::adc_sample_t      o_ic,
   output hbridge_pkg::dac_word_t        o_da,
   output hbridge_pkg::dac_word_t        o_db
);
   import hbridge_pkg::*;

   // negated samples, sign flip for the control law
   adc_sample_t neg_a;
   adc_sample_t neg_b;

   // two's complement, -(-8192) wraps back to -8192
   assign neg_a = -i_ada_data;
   assign neg_b = -i_adb_data;

   // =========================================================================
   // sample registers
   // =========================================================================

   always_ff @(posedge ADA_DCO) begin
      if (i_reset) begin
         o_vc <= '0;
         o_ic <= '0;
         o_da <= '0;
         o_db <= '0;
      end else begin
         // channel A is the tank voltage, B the tank current
         o_vc <= neg_a;
         o_ic <= neg_b;
         // shift to offset binary, wraps mod 2^14
         o_da <= dac_word_t'(neg_a) + DAC_OFFSET;
         o_db <= dac_word_t'(neg_b) + DAC_OFFSET;
      end
   end

   // dac copies stay in step with the samples they mirror
   a_dac_tracks_sample : assert property (@(posedge ADA_DCO) disable iff (i_reset)
      !$past(i_reset) |-> (o_da == dac_word_t'(o_vc) + DAC_OFFSET)
                       && (o_db == dac_word_t'(o_ic) + DAC_OFFSET))
      else $error("adc_capture: DAC copy does not match sample");

endmodule

`default_nettype wire

// ==== input_debounce.sv ====
`timescale 1ns/1ps
`default_nettype none

module input_debounce #(
   parameter int N               = 4,
   parameter int DEBOUNCE_CYCLES = 16
) (
   input  wire          i_reset,
   input  wire          ADA_DCO,
   input  wire  [N-1:0] i_raw,
   output logic [N-1:0] o_stable
);

   // wide enough to hold DEBOUNCE_CYCLES
   localparam int CW = $clog2(DEBOUNCE_CYCLES + 1);
   // last count before the stable bit flips
   localparam logic [CW-1:0] LAST_CNT = CW'(DEBOUNCE_CYCLES - 1);

   // one stability counter per input bit
   logic [CW-1:0] stab_cnt [N];

   // =========================================================================
   // per-bit stable-time filter
   // =========================================================================

   always_ff @(posedge ADA_DCO) begin
      if (i_reset) begin
         o_stable <= '0;
         for (int i = 0; i < N; i++) begin
            stab_cnt[i] <= '0;
         end
      end else begin
         for (int i = 0; i < N; i++) begin
            if (i_raw[i] == o_stable[i]) begin
               // bounce back or idle restarts the count
               stab_cnt[i] <= '0;
            end else if (stab_cnt[i] == LAST_CNT) begin
               // new level held long enough
               o_stable[i] <= i_raw[i];
               stab_cnt[i] <= '0;
            end else begin
               stab_cnt[i] <= stab_cnt[i] + 1'b1;
            end
         end
      end
   end

   // a stable bit only moves after its raw bit held the new level for the whole window
   for (genvar g = 0; g < N; g++) begin : g_chk
      for (genvar k = 1; k <= DEBOUNCE_CYCLES; k++) begin : g_hold
         a_flip_after_hold : assert property (@(posedge ADA_DCO) disable iff (i_reset)
            !$past(i_reset) && $changed(o_stable[g]) |-> $past(i_raw[g], k) == o_stable[g])
            else $error("input_debounce: bit %0d flipped before its input settled", g);
      end
   end

endmodule

`default_nettype wire

// ==== setpoint_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module setpoint_control #(
   parameter int PHI_STEP = 5,
   parameter int PHI_MIN  = 0,
   parameter int PHI_MAX  = 90
) (
   input  wire                  i_reset,
   input  wire                  ADA_DCO,
   input  wire                  i_clear,
   input  wire                  i_inc,
   input  wire                  i_dec,
   output hbridge_pkg::angle_t  o_phi
);
   import hbridge_pkg::*;

   localparam angle_t     MIN_A   = angle_t'(PHI_MIN);
   localparam angle_t     MAX_A   = angle_t'(PHI_MAX);
   localparam angle_t     STEP_A  = angle_t'(PHI_STEP);
   // 9-bit bounds, one spare bit for the up step
   localparam logic [8:0] MAX_W   = 9'(PHI_MAX);
   localparam logic [8:0] FLOOR_W = 9'(PHI_MIN + PHI_STEP);

   // previous button levels for edge detect
   logic   clear_q;
   logic   inc_q;
   logic   dec_q;
   logic   clear_rise;
   logic   inc_rise;
   logic   dec_rise;
   logic [8:0] phi_up;
   angle_t phi_next;

   assign clear_rise = i_clear & ~clear_q;
   assign inc_rise   = i_inc & ~inc_q;
   assign dec_rise   = i_dec & ~dec_q;

   assign phi_up = {1'b0, o_phi} + 9'(PHI_STEP);

   // =========================================================================
   // next phi, clear first, then inc over dec
   // =========================================================================

   always_comb begin
      phi_next = o_phi;
      if (clear_rise) begin
         phi_next = MIN_A;
      end else if (inc_rise) begin
         // clamp at the top
         phi_next = (phi_up > MAX_W) ? MAX_A : phi_up[7:0];
      end else if (dec_rise) begin
         // clamp at the bottom, no underflow
         phi_next = ({1'b0, o_phi} < FLOOR_W) ? MIN_A : o_phi - STEP_A;
      end
   end

   always_ff @(posedge ADA_DCO) begin
      if (i_reset) begin
         clear_q <= 1'b0;
         inc_q   <= 1'b0;
         dec_q   <= 1'b0;
         o_phi   <= MIN_A;
      end else begin
         clear_q <= i_clear;
         inc_q   <= i_inc;
         dec_q   <= i_dec;
         o_phi   <= phi_next;
      end
   end

   a_phi_in_range : assert property (@(posedge ADA_DCO) disable iff (i_reset)
      (o_phi >= MIN_A) && (o_phi <= MAX_A))
      else $error("setpoint_control: phi %0d outside its range", o_phi);

endmodule

`default_nettype wire

// ==== dead_time.sv ====
`timescale 1ns/1ps
`default_nettype none

module dead_time #(
   parameter int DT_SEL0 = 8,
   parameter int DT_SEL1 = 2,
   parameter int DT_SEL2 = 4,
   parameter int DT_SEL3 = 6
) (
   input  wire                 i_reset,
   input  wire                 ADA_DCO,
   input  wire [1:0]           i_dt_sel,
   input  wire hbridge_pkg::gate_t i_gate_cmd,
   output hbridge_pkg::gate_t  o_gate
);
   import hbridge_pkg::*;

   localparam int NG = $bits(gate_t);
   // shortest selectable dead time
   localparam int MIN_DT01 = (DT_SEL0 < DT_SEL1) ? DT_SEL0 : DT_SEL1;
   localparam int MIN_DT23 = (DT_SEL2 < DT_SEL3) ? DT_SEL2 : DT_SEL3;
   localparam int MIN_DT   = (MIN_DT01 < MIN_DT23) ? MIN_DT01 : MIN_DT23;

   // dead time picked by i_dt_sel every cycle
   dt_count_t dt_len;
   // high-time counter per gate
   dt_count_t hi_cnt [NG];

   // =========================================================================
   // dead time select
   // =========================================================================

   always_comb begin
      case (i_dt_sel)
         2'd0:    dt_len = dt_count_t'(DT_SEL0);
         2'd1:    dt_len = dt_count_t'(DT_SEL1);
         2'd2:    dt_len = dt_count_t'(DT_SEL2);
         default: dt_len = dt_count_t'(DT_SEL3);
      endcase
   end

   // =========================================================================
   // per-gate turn-on delay
   // =========================================================================

   // turn-off goes straight through and turn-on waits dt_len cycles
   always_ff @(posedge ADA_DCO) begin
      if (i_reset) begin
         o_gate <= '0;
         for (int i = 0; i < NG; i++) begin
            hi_cnt[i] <= '0;
         end
      end else begin
         for (int i = 0; i < NG; i++) begin
            if (!i_gate_cmd[i]) begin
               // command low drops the gate at once
               hi_cnt[i] <= '0;
               o_gate[i] <= 1'b0;
            end else if (hi_cnt[i] >= dt_len) begin
               // counter parks once the wait is over
               o_gate[i] <= 1'b1;
            end else begin
               hi_cnt[i] <= hi_cnt[i] + 1'b1;
            end
         end
      end
   end

   // a gate turns on only after its command held through the shortest dead time
   for (genvar g = 0; g < NG; g++) begin : g_chk
      for (genvar k = 1; k <= MIN_DT + 1; k++) begin : g_hold
         a_rise_after_dead_time : assert property (@(posedge ADA_DCO) disable iff (i_reset)
            $rose(o_gate[g]) |-> $past(i_gate_cmd[g], k))
            else $error("dead_time: gate %0d rose before the dead time", g);
      end
   end

endmodule

`default_nettype wire

// ==== bridge_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module bridge_sequencer #(
   parameter int BOOT_CYCLES   = 10,
   parameter int CHARGE_CYCLES = 16
) (
   input  wire                     i_reset,
   input  wire                     ADA_DCO,
   input  wire                     i_enable,
   input  wire hbridge_pkg::gate_t i_gate,
   output hbridge_pkg::gate_t      o_q
);
   import hbridge_pkg::*;

   localparam startup_cnt_t BOOT_LAST   = startup_cnt_t'(BOOT_CYCLES);
   localparam startup_cnt_t CHARGE_LAST = startup_cnt_t'(CHARGE_CYCLES);

   bridge_state_t state;
   startup_cnt_t  startup_cnt;
   gate_t         q_next;
   // both switches of one leg requested together
   logic          shoot_through;

   assign shoot_through = (i_gate[0] & i_gate[2]) | (i_gate[1] & i_gate[3]);

   // =========================================================================
   // start-up state machine
   // =========================================================================

   // bootstrap while cnt <= BOOT_CYCLES, force while cnt <= CHARGE_CYCLES
   always_ff @(posedge ADA_DCO) begin
      if (i_reset) begin
         state       <= st_off;
         startup_cnt <= '0;
      end else if (!i_enable) begin
         // bridge off and the sequence restarts on the next enable
         state       <= st_off;
         startup_cnt <= '0;
      end else begin
         case (state)
            st_off: begin
               state <= st_bootstrap;
            end
            st_bootstrap: begin
               startup_cnt <= startup_cnt + 1'b1;
               if (startup_cnt >= BOOT_LAST) begin
                  state <= st_force;
               end
            end
            st_force: begin
               startup_cnt <= startup_cnt + 1'b1;
               if (startup_cnt >= CHARGE_LAST) begin
                  state <= st_run;
               end
            end
            default: begin
               // running with the counter frozen
               state <= st_run;
            end
         endcase
      end
   end

   // =========================================================================
   // gate selection and output register
   // =========================================================================

   always_comb begin
      case (state)
         st_bootstrap: q_next = GATES_BOOTSTRAP;
         st_force:     q_next = GATES_FORCE;
         st_run:       q_next = shoot_through ? gate_t'(0) : i_gate;
         default:      q_next = '0;
      endcase
      // enable low kills the gates without waiting for the FSM
      if (!i_enable) begin
         q_next = '0;
      end
   end

   always_ff @(posedge ADA_DCO) begin
      if (i_reset) begin
         o_q <= '0;
      end else begin
         o_q <= q_next;
      end
   end

   a_no_shoot_through : assert property (@(posedge ADA_DCO) disable iff (i_reset)
      !((o_q[0] && o_q[2]) || (o_q[1] && o_q[3])))
      else $error("bridge_sequencer: both gates of a leg on, q=%b", o_q);

endmodule

`default_nettype wire

// ==== hbridge_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module hbridge_top #(
   parameter int DEBOUNCE_CYCLES = 16,
   parameter int PHI_STEP        = 5,
   parameter int PHI_MIN         = 0,
   parameter int PHI_MAX         = 90,
   parameter int DT_SEL0         = 8,
   parameter int DT_SEL1         = 2,
   parameter int DT_SEL2         = 4,
   parameter int DT_SEL3         = 6,
   parameter int BOOT_CYCLES     = 10,
   parameter int CHARGE_CYCLES   = 16
) (
   input  wire                           ADA_DCO,
   input  wire                           i_reset,
   // tank adc samples, two's complement
   input  wire hbridge_pkg::adc_sample_t i_ada_data,
   input  wire hbridge_pkg::adc_sample_t i_adb_data,
   // buttons: 0 clear, 1 inc, 2 dec
   input  wire [3:0]                     i_button,
   // switches: 0 bridge enable
   input  wire [3:0]                     i_sw,
   input  wire [1:0]                     i_dt_sel,
   // switching command from the control law
   input  wire hbridge_pkg::gate_t       i_gate_cmd,
   output hbridge_pkg::adc_sample_t      o_vc,
   output hbridge_pkg::adc_sample_t      o_ic,
   output hbridge_pkg::dac_word_t        o_da,
   output hbridge_pkg::dac_word_t        o_db,
   output hbridge_pkg::angle_t           o_phi,
   output hbridge_pkg::gate_t            o_q
);
   import hbridge_pkg::*;

   logic [3:0] button_stable;
   logic [3:0] sw_stable;
   // commands after dead time insertion
   gate_t      gate_dt;

   // =========================================================================
   // sensing path
   // =========================================================================

   adc_capture u_adc_capture (
      .i_reset    (i_reset),
      .ADA_DCO    (ADA_DCO),
      .i_ada_data (i_ada_data),
      .i_adb_data (i_adb_data),
      .o_vc       (o_vc),
      .o_ic       (o_ic),
      .o_da       (o_da),
      .o_db       (o_db)
   );

   // user inputs
   input_debounce #(
      .N               (4),
      .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
   ) button_db (
      .i_reset  (i_reset),
      .ADA_DCO  (ADA_DCO),
      .i_raw    (i_button),
      .o_stable (button_stable)
   );

   input_debounce #(
      .N               (4),
      .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
   ) switch_db (
      .i_reset  (i_reset),
      .ADA_DCO  (ADA_DCO),
      .i_raw    (i_sw),
      .o_stable (sw_stable)
   );

   setpoint_control #(
      .PHI_STEP (PHI_STEP),
      .PHI_MIN  (PHI_MIN),
      .PHI_MAX  (PHI_MAX)
   ) u_setpoint_control (
      .i_reset (i_reset),
      .ADA_DCO (ADA_DCO),
      .i_clear (button_stable[0]),
      .i_inc   (button_stable[1]),
      .i_dec   (button_stable[2]),
      .o_phi   (o_phi)
   );

   // =========================================================================
   // gate drive path
   // =========================================================================

   dead_time #(
      .DT_SEL0 (DT_SEL0),
      .DT_SEL1 (DT_SEL1),
      .DT_SEL2 (DT_SEL2),
      .DT_SEL3 (DT_SEL3)
   ) u_dead_time (
      .i_reset    (i_reset),
      .ADA_DCO    (ADA_DCO),
      .i_dt_sel   (i_dt_sel),
      .i_gate_cmd (i_gate_cmd),
      .o_gate     (gate_dt)
   );

   bridge_sequencer #(
      .BOOT_CYCLES   (BOOT_CYCLES),
      .CHARGE_CYCLES (CHARGE_CYCLES)
   ) u_bridge_sequencer (
      .i_reset  (i_reset),
      .ADA_DCO  (ADA_DCO),
      .i_enable (sw_stable[0]),
      .i_gate   (gate_dt),
      .o_q      (o_q)
   );

endmodule

`default_nettype wire

// ==== tb_hbridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_hbridge;
   import hbridge_pkg::*;

   localparam int DEBOUNCE_CYCLES = 16;
   // top level defaults for the reference model
   localparam int PHI_STEP      = 5;
   localparam int PHI_MIN       = 0;
   localparam int PHI_MAX       = 90;
   localparam int BOOT_CYCLES   = 10;
   localparam int CHARGE_CYCLES = 16;
   localparam int DAC_MID       = 8191;
   // M3+M4 for bootstrap, M1+M4 for the forced state
   localparam logic [3:0] EXP_BOOT  = 4'b1100;
   localparam logic [3:0] EXP_FORCE = 4'b1001;
   localparam logic [3:0] RUN_CMD   = 4'b0011;
   // dead time register plus sequencer output register
   localparam int PIPE_DELAY  = 2;
   localparam int PRESS_TICKS = 2 * DEBOUNCE_CYCLES + 10;
   localparam int N_PRESSES   = 64;
   localparam int TEST_CYCLES = 200 + 4 * 60 + 60 * 9 + 3 * 20 + 80
                                + N_PRESSES * PRESS_TICKS;
   localparam int WATCHDOG_CYCLES = TEST_CYCLES + TEST_CYCLES / 4;

   logic        ADA_DCO;
   logic        i_reset;
   adc_sample_t i_ada_data;
   adc_sample_t i_adb_data;
   logic [3:0]  i_button;
   logic [3:0]  i_sw;
   logic [1:0]  i_dt_sel;
   gate_t       i_gate_cmd;
   adc_sample_t o_vc;
   adc_sample_t o_ic;
   dac_word_t   o_da;
   dac_word_t   o_db;
   angle_t      o_phi;
   gate_t       o_q;

   int checks       = 0;
   int value_errors = 0;
   int other_errors = 0;
   int cyc          = 0;
   int exp_phi      = PHI_MIN;
   int dt_exp [4]   = '{8, 2, 4, 6};

   // adc history for the one-cycle model
   adc_sample_t adc_a_q;
   adc_sample_t adc_b_q;
   logic        adc_rst_q = 1'b1;

   hbridge_top #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) dut (
      .ADA_DCO    (ADA_DCO),
      .i_reset    (i_reset),
      .i_ada_data (i_ada_data),
      .i_adb_data (i_adb_data),
      .i_button   (i_button),
      .i_sw       (i_sw),
      .i_dt_sel   (i_dt_sel),
      .i_gate_cmd (i_gate_cmd),
      .o_vc       (o_vc),
      .o_ic       (o_ic),
      .o_da       (o_da),
      .o_db       (o_db),
      .o_phi      (o_phi),
      .o_q        (o_q)
   );

   always #10 ADA_DCO = ~ADA_DCO;

   // ==========================================================================
   // reference models and check helpers
   // ==========================================================================

   // invert and add one in 14 bits
   function automatic adc_sample_t negate_sample(input adc_sample_t x);
      return ~x + 14'sd1;
   endfunction

   function automatic int dac_expected(input adc_sample_t x);
      return (int'(dac_word_t'(negate_sample(x))) + DAC_MID) % 16384;
   endfunction

   // kind 0 clear, 1 inc, 2 dec
   function automatic int next_phi(input int phi, input int kind);
      int res;
      res = phi;
      if (kind == 0) res = PHI_MIN;
      else if (kind == 1) res = (phi + PHI_STEP > PHI_MAX) ? PHI_MAX : phi + PHI_STEP;
      else if (kind == 2) res = (phi - PHI_STEP < PHI_MIN) ? PHI_MIN : phi - PHI_STEP;
      return res;
   endfunction

   task automatic check_value(input string name, input int exp, input int act);
      checks++;
      assert (act == exp)
         else begin
            value_errors++;
            $display("Error %s: expected %0d, actual %0d", name, exp, act);
         end
   endtask

   task automatic check_range(input string name, input int lo, input int hi, input int act);
      checks++;
      assert (act >= lo && act <= hi)
         else begin
            value_errors++;
            $display("Error %s: expected %0d to %0d, actual %0d", name, lo, hi, act);
         end
   endtask

   // starts and ends on a falling edge
   task automatic measure_run(output gate_t val, output int len);
      val = o_q;
      len = 0;
      while (o_q == val && len < 100) begin
         len++;
         @(negedge ADA_DCO);
      end
   endtask

   task automatic hold_q_zero(input string name, input int n);
      repeat (n) begin
         @(negedge ADA_DCO);
         check_value(name, 0, o_q);
      end
   endtask

   // raw pulse on one button and a release long enough to settle
   task automatic press(input int idx, input int hold);
      @(posedge ADA_DCO);
      i_button <= i_button | (4'b0001 << idx);
      repeat (hold) @(posedge ADA_DCO);
      i_button <= '0;
      repeat (DEBOUNCE_CYCLES + 4) @(posedge ADA_DCO);
   endtask

   task automatic full_press(input int kind, input string name);
      press(kind, DEBOUNCE_CYCLES + 4);
      exp_phi = next_phi(exp_phi, kind);
      @(negedge ADA_DCO);
      check_value(name, exp_phi, o_phi);
   endtask

   // ==========================================================================
   // continuous checks
   // ==========================================================================

   // fresh samples every cycle with full-scale negative now and then
   always @(posedge ADA_DCO) begin
      cyc <= cyc + 1;
      i_ada_data <= (cyc % 61 == 0) ? 14'sh2000 : adc_sample_t'($urandom);
      i_adb_data <= adc_sample_t'($urandom);
      adc_a_q <= i_ada_data;
      adc_b_q <= i_adb_data;
      adc_rst_q <= i_reset;
   end

   always @(negedge ADA_DCO) begin
      if (!adc_rst_q) begin
         check_value("adc vc", int'(negate_sample(adc_a_q)), int'(o_vc));
         check_value("adc ic", int'(negate_sample(adc_b_q)), int'(o_ic));
         check_value("adc da", dac_expected(adc_a_q), int'(o_da));
         check_value("adc db", dac_expected(adc_b_q), int'(o_db));
      end
   end

   a_leg_exclusive : assert property (@(posedge ADA_DCO) disable iff (i_reset)
      !((o_q[0] && o_q[2]) || (o_q[1] && o_q[3])))
      else begin
         other_errors++;
         $display("Error: both gates of one bridge leg are on at o_q");
      end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge ADA_DCO);
      $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
      $display("TEST FAIL");
      $finish;
   end

   // ==========================================================================
   // main sequence
   // ==========================================================================

   initial begin
      int    k;
      gate_t v;
      void'($urandom(77816));
      ADA_DCO    = 1'b0;
      i_reset    = 1'b1;
      i_ada_data = '0;
      i_adb_data = '0;
      i_button   = '0;
      i_sw       = '0;
      i_dt_sel   = '0;
      i_gate_cmd = '0;
      repeat (4) @(posedge ADA_DCO);
      i_reset    <= 1'b0;
      i_gate_cmd <= RUN_CMD;
      // bridge stays off without the enable
      hold_q_zero("q before enable", 20);

      // start-up order and phase lengths
      @(posedge ADA_DCO);
      i_sw <= 4'b0001;
      @(negedge ADA_DCO);
      measure_run(v, k);
      check_value("startup idle gates", 0, v);
      check_range("startup idle length", DEBOUNCE_CYCLES, DEBOUNCE_CYCLES + 4, k);
      measure_run(v, k);
      check_value("bootstrap gates", EXP_BOOT, v);
      check_value("bootstrap length", BOOT_CYCLES + 1, k);
      measure_run(v, k);
      check_value("force gates", EXP_FORCE, v);
      check_value("force length", CHARGE_CYCLES - BOOT_CYCLES, k);
      check_value("run gates", RUN_CMD, o_q);

      // dead time per select value with one gate each
      for (int sel = 0; sel < 4; sel++) begin
         @(posedge ADA_DCO);
         i_dt_sel   <= sel[1:0];
         i_gate_cmd <= '0;
         repeat (3) @(posedge ADA_DCO);
         i_gate_cmd <= gate_t'(1 << sel);
         k = 0;
         @(negedge ADA_DCO);
         while (!o_q[sel] && k < 40) begin
            k++;
            @(negedge ADA_DCO);
         end
         check_range("dead time rise", dt_exp[sel] + PIPE_DELAY, dt_exp[sel] + PIPE_DELAY + 1, k);
         @(posedge ADA_DCO);
         i_gate_cmd <= '0;
         k = 0;
         @(negedge ADA_DCO);
         while (o_q[sel] && k < 40) begin
            k++;
            @(negedge ADA_DCO);
         end
         check_range("dead time fall", 0, 2, k);
      end

      // random commands while the leg assertion watches o_q
      @(posedge ADA_DCO);
      i_dt_sel <= 2'd1;
      for (int n = 0; n < 60; n++) begin
         @(posedge ADA_DCO);
         i_gate_cmd <= gate_t'($urandom);
         repeat ($urandom_range(7, 0)) @(posedge ADA_DCO);
      end

      // leg shorts held past the dead time
      for (int i = 0; i < 3; i++) begin
         @(posedge ADA_DCO);
         i_gate_cmd <= (i == 0) ? 4'b0101 : (i == 1) ? 4'b1010 : 4'b1111;
         repeat (12) @(posedge ADA_DCO);
         @(negedge ADA_DCO);
         check_value("shoot-through blocked", 0, o_q);
      end

      // enable drop
      @(posedge ADA_DCO);
      i_gate_cmd <= RUN_CMD;
      repeat (12) @(posedge ADA_DCO);
      @(negedge ADA_DCO);
      check_value("run before disable", RUN_CMD, o_q);
      @(posedge ADA_DCO);
      i_sw <= '0;
      k = 0;
      @(negedge ADA_DCO);
      while (o_q != '0 && k < 40) begin
         k++;
         @(negedge ADA_DCO);
      end
      check_range("gates off after disable", DEBOUNCE_CYCLES, DEBOUNCE_CYCLES + 2, k);
      hold_q_zero("q after disable", 20);

      // phi stepping and clamps
      full_press(0, "phi clear");
      repeat (3) full_press(1, "phi inc");
      full_press(2, "phi dec");
      repeat (20) full_press(1, "phi inc to max");
      repeat (20) full_press(2, "phi dec to min");
      repeat (4) full_press(1, "phi inc");
      // glitches shorter than the debounce window
      press(1, 1);
      press(2, 8);
      press(0, DEBOUNCE_CYCLES - 1);
      press(1, DEBOUNCE_CYCLES - 1);
      @(negedge ADA_DCO);
      check_value("phi after short pulses", exp_phi, o_phi);
      full_press(0, "phi clear");
      repeat (10) full_press($urandom_range(2, 0), "phi random press");

      repeat (4) @(posedge ADA_DCO);
      $display("checks %0d, value errors %0d, other errors %0d",
               checks, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== hbridge_ctrl.f ====
hbridge_pkg.sv
adc_capture.sv
input_debounce.sv
setpoint_control.sv
dead_time.sv
bridge_sequencer.sv
hbridge_top.sv
tb_hbridge.sv
